/* src.f */
+incdir+src
src/core_pkg.sv
src/core_if.sv
src/id_manager.sv
src/decode_unit.sv
src/execute_units.sv
src/result_commit.sv
src/core_top.sv
testbench/tb_core.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat src.f)) src/core_settings.svh

.PHONY: run clean

run: obj_dir/Vtb_core
	@out="$$(./obj_dir/Vtb_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

obj_dir/Vtb_core: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core -f src.f

clean:
	rm -rf obj_dir

/* testbench/tb_core.sv */
`timescale 1ns/10ps
`include "core_settings.svh"
`default_nettype none

module tb_core;
    import core_pkg::*;

    // Opcodes as laid out in the top nibble of a word
    localparam logic [3:0] OP_ADD = 4'h0;
    localparam logic [3:0] OP_SUB = 4'h1;
    localparam logic [3:0] OP_XOR = 4'h2;
    localparam logic [3:0] OP_AND = 4'h3;
    localparam logic [3:0] OP_ADDI = 4'h4;
    localparam logic [3:0] OP_MUL = 4'h5;

    logic clk;
    logic rst;
    logic in_valid;
    logic [31:0] in_instr;
    logic in_ready;
    logic [1:0] commit_valid;
    reg_addr_t commit_rd [2];
    logic [31:0] commit_data [2];
    id_t commit_id [2];
    logic retire_valid;
    logic [1:0] retire_count;
    id_t retire_rd_id;

    // Reference model, architectural state in program order
    logic [31:0] model_regs [8] = '{default: '0};
    logic [31:0] last_commit [8] = '{default: '0};
    // Expected results looked up by ID
    logic [31:0] exp_data [`MAX_IDS] = '{default: '0};
    reg_addr_t exp_rd [`MAX_IDS] = '{default: '0};
    logic exp_writes [`MAX_IDS] = '{default: 1'b0};
    // Pending commits as {id, rd, data}, oldest first
    logic [37:0] commit_q [$];
    // IDs of rd writers still to retire
    id_t retire_q [$];

    int accepted = 0;
    int retired = 0;
    int commits_seen = 0;
    int mon_errors = 0;
    int main_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    integer seed;

    core_top dut (
        .clk (clk),
        .rst (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data),
        .commit_id (commit_id),
        .retire_valid (retire_valid),
        .retire_count (retire_count),
        .retire_rd_id (retire_rd_id)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hard stop in case a wait loop itself misbehaves
    initial begin
        #100_000;
        $display("Simulation ran past its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int total_errors();
        return mon_errors + main_errors;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    task automatic model_accept(input logic [31:0] word);
        logic [3:0] op;
        reg_addr_t rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_ext;
        logic [31:0] res;
        logic writes;
        id_t id;
        op = word[31:28];
        rd = word[27:25];
        a = model_regs[word[24:22]];
        b = model_regs[word[21:19]];
        imm_ext = {{16{word[15]}}, word[15:0]};
        writes = (rd != 3'd0);
        case (op)
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_XOR: res = a ^ b;
            OP_AND: res = a & b;
            OP_ADDI: res = a + imm_ext;
            // Low half of the product only
            OP_MUL: res = a * b;
            default: begin
                res = '0;
                writes = 1'b0;
            end
        endcase
        // IDs handed out in order, wrapping at the table depth
        id = id_t'(accepted % `MAX_IDS);
        accepted = accepted + 1;
        exp_data[id] = res;
        exp_rd[id] = rd;
        exp_writes[id] = writes;
        if (writes) begin
            model_regs[rd] = res;
            commit_q.push_back({id, rd, res});
            retire_q.push_back(id);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle checks at the falling edge
    task automatic check_commit(input int lane);
        id_t cid;
        reg_addr_t crd;
        logic [31:0] cdata;
        int found;
        cid = commit_id[lane];
        crd = commit_rd[lane];
        cdata = commit_data[lane];
        commits_seen = commits_seen + 1;
        last_commit[crd] = cdata;
        if (crd == 3'd0) begin
            mon_errors++;
            $display("** Error: commit_rd[%0d] = 0x%h, expected nonzero", lane, crd);
        end
        if (!exp_writes[cid]) begin
            mon_errors++;
            $display("Commit seen for id %0d, which writes no register", cid);
        end else begin
            if (exp_rd[cid] !== crd) begin
                mon_errors++;
                $display("** Error: commit_rd[%0d] = 0x%h, expected 0x%h", lane, crd, exp_rd[cid]);
            end
            if (exp_data[cid] !== cdata) begin
                mon_errors++;
                $display("** Error: commit_data[%0d] = 0x%h, expected 0x%h",
                    lane, cdata, exp_data[cid]);
            end
        end
        // Oldest pending write to this rd must be the one committing
        found = -1;
        for (int i = 0; i < commit_q.size(); i++) begin
            if (found < 0 && commit_q[i][34:32] == crd) begin
                found = i;
            end
        end
        if (found < 0) begin
            mon_errors++;
            $display("Commit to x%0d that the model does not expect", crd);
        end else begin
            if (commit_q[found][37:35] !== cid) begin
                mon_errors++;
                $display("** Error: commit_id[%0d] = 0x%h, expected 0x%h",
                    lane, cid, commit_q[found][37:35]);
            end
            commit_q.delete(found);
        end
    endtask

    task automatic check_cycle();
        logic ready_exp;
        retired = retired + int'(retire_count);
        // Back-pressure exactly at a full ID space
        ready_exp = (accepted - retired) != `MAX_IDS;
        if (in_ready !== ready_exp) begin
            mon_errors++;
            $display("** Error: in_ready = 0x%h, expected 0x%h", in_ready, ready_exp);
        end
        if (retire_valid) begin
            if (retire_q.size() == 0) begin
                mon_errors++;
                $display("Register retire seen with no rd writer outstanding");
            end else begin
                if (retire_rd_id !== retire_q[0]) begin
                    mon_errors++;
                    $display("** Error: retire_rd_id = 0x%h, expected 0x%h",
                        retire_rd_id, retire_q[0]);
                end
                retire_q.delete(0);
            end
        end
        for (int g = 0; g < 2; g++) begin
            if (commit_valid[g]) begin
                check_commit(g);
            end
        end
        if (in_valid && in_ready) begin
            model_accept(in_instr);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_cycle();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic drive_random();
        logic [31:0] word;
        word = $random(seed);
        word[31:28] = 4'({$random(seed)} % 7);
        in_valid = ({$random(seed)} % 4) != 0;
        in_instr = word;
    endtask

    // Same rd throughout, so WAW stalls keep IDs in flight
    task automatic drive_mul();
        logic [31:0] word;
        word = $random(seed);
        word[31:28] = OP_MUL;
        word[27:25] = 3'd5;
        in_valid = 1'b1;
        in_instr = word;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (accepted != retired && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted != retired) begin
            main_errors++;
            $display("Drain timed out with %0d accepted and %0d retired", accepted, retired);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = total_errors() - errors_before;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, new_errors);
        end
    endtask

    initial begin
        int errors_before;
        int cycles;
        logic reached;
        seed = 32'h9614_4f3a;
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;

        // Reset state, sampled before release
        errors_before = total_errors();
        repeat (10) @(posedge clk);
        #2;
        if (in_ready !== 1'b1) begin
            main_errors++;
            $display("** Error: in_ready = 0x%h, expected 0x1", in_ready);
        end
        if (commit_valid !== 2'b00) begin
            main_errors++;
            $display("** Error: commit_valid = 0x%h, expected 0x0", commit_valid);
        end
        if (retire_count !== 2'b00) begin
            main_errors++;
            $display("** Error: retire_count = 0x%h, expected 0x0", retire_count);
        end
        rst = 1'b0;
        report_test("reset", errors_before);

        // Mixed ops, random registers and immediates
        errors_before = total_errors();
        repeat (400) begin
            @(posedge clk);
            #2;
            drive_random();
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        wait_drained();
        report_test("random_stream", errors_before);

        // Multiplies only, until the ID space fills
        errors_before = total_errors();
        reached = 1'b0;
        cycles = 0;
        while (!reached && cycles < 60) begin
            @(posedge clk);
            #2;
            if (!in_ready) begin
                reached = 1'b1;
            end else begin
                drive_mul();
            end
            cycles++;
        end
        if (!reached) begin
            main_errors++;
            $display("in_ready never went low during the multiply burst");
        end
        // Keep pushing while full, nothing may be taken
        repeat (3) begin
            @(posedge clk);
            #2;
            drive_mul();
        end
        in_valid = 1'b0;
        wait_drained();
        report_test("mul_burst", errors_before);

        // Architectural state and totals after draining
        errors_before = total_errors();
        for (int r = 1; r < 8; r++) begin
            if (last_commit[r] !== model_regs[r]) begin
                main_errors++;
                $display("** Error: x%0d = 0x%h, expected 0x%h", r, last_commit[r], model_regs[r]);
            end
        end
        if (retired != accepted) begin
            main_errors++;
            $display("** Error: retire_count total = 0x%h, expected 0x%h", retired, accepted);
        end
        if (commit_q.size() != 0) begin
            main_errors++;
            $display("%0d expected commits never appeared", commit_q.size());
        end
        if (retire_q.size() != 0) begin
            main_errors++;
            $display("%0d register writers never retired", retire_q.size());
        end
        report_test("final_state", errors_before);

        $display("%0d tests, %0d failed, %0d errors, %0d accepted, %0d commits",
            tests_run, tests_failed, total_errors(), accepted, commits_seen);
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input logic clk,
    input logic rst,

    input logic in_valid,
    input logic [31:0] in_instr,
    output logic in_ready,

    output logic [1:0] commit_valid,
    output core_pkg::reg_addr_t commit_rd [2],
    output logic [31:0] commit_data [2],
    output core_pkg::id_t commit_id [2],

    output logic retire_valid,
    output logic [1:0] retire_count,
    output core_pkg::id_t retire_rd_id
);
    import core_pkg::*;

    logic in_accept;
    decode_packet_t decode;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    retire_packet_t retire;

    issue_if iss ();
    wb_if wb ();

    assign in_accept = in_valid & in_ready;

    id_manager id_mgr (
        .clk (clk),
        .rst (rst),
        .in_accept (in_accept),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .decode (decode),
        .iss (iss.monitor),
        .wb (wb.sink),
        .retire (retire),
        .retire_ids (),
        .retire_port_valid ()
    );

    decode_unit dec (
        .clk (clk),
        .rst (rst),
        .decode (decode),
        .decode_advance (),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .iss (iss.decode_side),
        .wb (wb.sink)
    );

    execute_units exe (
        .clk (clk),
        .rst (rst),
        .iss (iss.exec_side),
        .wb (wb.source)
    );

    result_commit res (
        .clk (clk),
        .rst (rst),
        .wb (wb.sink),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_id (commit_id),
        .commit_data (commit_data)
    );

    assign retire_valid = retire.valid;
    assign retire_count = retire.count;
    assign retire_rd_id = retire.rd_id;

endmodule

`default_nettype wire

/* src/result_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module result_commit (
    input logic clk,
    input logic rst,
    wb_if.sink wb,

    // Read ports for decode
    input core_pkg::reg_addr_t rs1_addr,
    input core_pkg::reg_addr_t rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,

    // One commit lane per writeback group
    output logic [1:0] commit_valid,
    output core_pkg::reg_addr_t commit_rd [2],
    output core_pkg::id_t commit_id [2],
    output logic [31:0] commit_data [2]
);
    import core_pkg::*;

    logic [31:0] regs [8];

    // Both groups write here, x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 8; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int g = 0; g < 2; g++) begin
                if (wb.pkt[g].valid & (|wb.pkt[g].rd)) begin
                    regs[wb.pkt[g].rd] <= wb.pkt[g].data;
                end
            end
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Commit is the writeback itself, minus x0 targets
    always_comb begin
        for (int g = 0; g < 2; g++) begin
            commit_valid[g] = wb.pkt[g].valid & (|wb.pkt[g].rd);
            commit_rd[g] = wb.pkt[g].rd;
            commit_id[g] = wb.pkt[g].id;
            commit_data[g] = wb.pkt[g].data;
        end
    end

    // Scoreboard in decode keeps the two groups apart
    distinct_write_targets: assert property (
        @(posedge clk) disable iff (rst)
        !(commit_valid[0] & commit_valid[1] & (wb.pkt[0].rd == wb.pkt[1].rd)))
        else $error("Both groups write x%0d in one cycle", wb.pkt[0].rd);

endmodule

`default_nettype wire

/* src/execute_units.sv */
`timescale 1ns/10ps
`include "core_settings.svh"
`default_nettype none

module execute_units (
    input logic clk,
    input logic rst,
    issue_if.exec_side iss,
    wb_if.source wb
);
    import core_pkg::*;

    localparam int MUL_LAT = `MUL_LATENCY;

    logic [31:0] alu_result;
    logic alu_valid;
    id_t alu_id;
    reg_addr_t alu_rd;
    logic [31:0] alu_data;

    // Multiplier pipeline, index 0 is the first stage
    logic [MUL_LAT-1:0] mul_valid;
    id_t mul_id [MUL_LAT];
    reg_addr_t mul_rd [MUL_LAT];
    logic [31:0] mul_data [MUL_LAT];

    ////////////////////////////////////////////////////////////
    // ALU, group 0
    always_comb begin
        case (iss.op)
            ADD: alu_result = iss.operand_a + iss.operand_b;
            SUB: alu_result = iss.operand_a - iss.operand_b;
            XOR: alu_result = iss.operand_a ^ iss.operand_b;
            AND: alu_result = iss.operand_a & iss.operand_b;
            // Immediate already sign extended in decode
            ADDI: alu_result = iss.operand_a + iss.operand_b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= iss.issue_alu;
        end
    end

    always_ff @(posedge clk) begin
        alu_id <= iss.id;
        alu_rd <= iss.rd;
        alu_data <= alu_result;
    end

    ////////////////////////////////////////////////////////////
    // Multiplier, group 1
    // Low product formed in the first stage and carried along
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= '0;
        end else begin
            mul_valid <= {mul_valid[MUL_LAT-2:0], iss.issue_mul};
        end
    end

    always_ff @(posedge clk) begin
        mul_id[0] <= iss.id;
        mul_rd[0] <= iss.rd;
        mul_data[0] <= iss.operand_a * iss.operand_b;
        for (int s = 1; s < MUL_LAT; s++) begin
            mul_id[s] <= mul_id[s-1];
            mul_rd[s] <= mul_rd[s-1];
            mul_data[s] <= mul_data[s-1];
        end
    end

    // Writeback packets
    assign wb.pkt[0] = '{valid: alu_valid, id: alu_id, rd: alu_rd, data: alu_data};
    assign wb.pkt[1] = '{
        valid: mul_valid[MUL_LAT-1],
        id: mul_id[MUL_LAT-1],
        rd: mul_rd[MUL_LAT-1],
        data: mul_data[MUL_LAT-1]
    };

endmodule

`default_nettype wire

/* src/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input logic clk,
    input logic rst,
    input core_pkg::decode_packet_t decode,
    output logic decode_advance,

    // Register file read ports
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input logic [31:0] rs1_data,
    input logic [31:0] rs2_data,

    issue_if.decode_side iss,
    wb_if.sink wb
);
    import core_pkg::*;

    op_t op;
    reg_addr_t rd;
    logic is_mul;
    logic is_i_fmt;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic stall;
    logic [31:0] imm_ext;

    // One bit per register, set while a write is outstanding
    logic [7:0] scoreboard;

    // Op, rd and rs1 share positions in both formats
    assign op = decode.instr.r_fmt.op;
    assign rd = decode.instr.r_fmt.rd;
    assign rs1_addr = decode.instr.r_fmt.rs1;
    assign rs2_addr = decode.instr.r_fmt.rs2;

    assign is_mul = (op == MUL);
    assign is_i_fmt = (op == ADDI);
    assign imm_ext = {{16{decode.instr.i_fmt.imm[15]}}, decode.instr.i_fmt.imm};

    always_comb begin
        case (op)
            ADD, SUB, XOR, AND, MUL: uses_rs2 = 1'b1;
            default: uses_rs2 = 1'b0;
        endcase
    end

    // NOP and unknown ops read nothing
    assign uses_rs1 = uses_rs2 | is_i_fmt;
    assign uses_rd = writes_rd(decode.instr);

    // No bypass, a register written this cycle is still busy
    assign stall = (uses_rs1 & scoreboard[rs1_addr])
        | (uses_rs2 & scoreboard[rs2_addr])
        | (uses_rd & scoreboard[rd]);

    assign decode_advance = decode.valid & ~stall;

    ////////////////////////////////////////////////////////////
    // Issue
    assign iss.issue_alu = decode_advance & ~is_mul;
    assign iss.issue_mul = decode_advance & is_mul;
    assign iss.id = decode.id;
    // rd forced to x0 when nothing is written
    assign iss.rd = uses_rd ? rd : '0;
    assign iss.op = op;
    assign iss.operand_a = rs1_data;
    assign iss.operand_b = is_i_fmt ? imm_ext : rs2_data;

    // Clear on writeback, set on issue, x0 never set
    always_ff @(posedge clk) begin
        if (rst) begin
            scoreboard <= '0;
        end else begin
            for (int g = 0; g < 2; g++) begin
                if (wb.pkt[g].valid) begin
                    scoreboard[wb.pkt[g].rd] <= 1'b0;
                end
            end
            if (decode_advance & uses_rd) begin
                scoreboard[rd] <= 1'b1;
            end
        end
    end

    // A register writeback always ends a write that issue marked busy
    writeback_matches_scoreboard: assert property (
        @(posedge clk) disable iff (rst)
        !(wb.pkt[0].valid & (|wb.pkt[0].rd) & ~scoreboard[wb.pkt[0].rd])
        && !(wb.pkt[1].valid & (|wb.pkt[1].rd) & ~scoreboard[wb.pkt[1].rd]))
        else $error("Writeback to a register with no write outstanding");

endmodule

`default_nettype wire

/* src/id_manager.sv */
`timescale 1ns/10ps
`include "core_settings.svh"
`default_nettype none

module id_manager (
    input logic clk,
    input logic rst,

    // Accept strobe assigns an ID and writes the word in one go
    input logic in_accept,
    input logic [31:0] in_instr,
    output logic in_ready,

    output core_pkg::decode_packet_t decode,

    issue_if.monitor iss,
    wb_if.sink wb,

    output core_pkg::retire_packet_t retire,
    output core_pkg::id_t retire_ids [`RETIRE_PORTS],
    output logic retire_port_valid [`RETIRE_PORTS]
);
    import core_pkg::*;

    localparam int COUNT_W = `LOG2_MAX_IDS + 1;

    instr_t instr_table [`MAX_IDS];
    logic uses_rd_table [`MAX_IDS];

    id_t alloc_id;
    id_t decode_id;
    logic decode_advance;

    logic [COUNT_W-1:0] fetched_count_neg;
    logic [COUNT_W-1:0] post_issue_count;
    logic [COUNT_W-1:0] inflight_count;

    // Two toggle tables, an ID is busy while they differ
    logic [`MAX_IDS-1:0] issue_toggle;
    logic [`MAX_IDS-1:0] wb_toggle;

    retire_packet_t retire_next;
    id_t retire_ids_next [`RETIRE_PORTS];
    logic retire_port_valid_next [`RETIRE_PORTS];
    logic [`RETIRE_PORTS-1:0] retire_id_uses_rd;
    logic [`RETIRE_PORTS-1:0] retire_id_inuse;
    logic contiguous;

    // Decode and issue happen in the same cycle
    assign decode_advance = iss.issue_alu | iss.issue_mul;

    ////////////////////////////////////////////////////////////
    // Tables
    always_ff @(posedge clk) begin
        if (in_accept) begin
            instr_table[alloc_id] <= in_instr;
        end
    end

    // Read back by the retirer to limit rd writers per cycle
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            uses_rd_table[decode_id] <= writes_rd(decode.instr);
        end
    end

    ////////////////////////////////////////////////////////////
    // ID counters
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_id <= '0;
            decode_id <= '0;
        end else begin
            alloc_id <= alloc_id + id_t'(in_accept);
            decode_id <= decode_id + id_t'(decode_advance);
        end
    end

    // Oldest IDs, each port one ahead of the previous
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RETIRE_PORTS; i++) begin
                retire_ids_next[i] <= id_t'(i);
            end
        end else begin
            for (int i = 0; i < `RETIRE_PORTS; i++) begin
                retire_ids_next[i] <= retire_ids_next[i] + id_t'(retire_next.count);
            end
        end
    end

    always_ff @(posedge clk) begin
        retire_ids <= retire_ids_next;
    end

    // Fetched count kept negative, MSB set means decode holds a word
    always_ff @(posedge clk) begin
        if (rst) begin
            fetched_count_neg <= '0;
            post_issue_count <= '0;
            inflight_count <= '0;
        end else begin
            fetched_count_neg <= fetched_count_neg + COUNT_W'(decode_advance)
                - COUNT_W'(in_accept);
            post_issue_count <= post_issue_count + COUNT_W'(decode_advance)
                - COUNT_W'(retire_next.count);
            inflight_count <= inflight_count + COUNT_W'(in_accept)
                - COUNT_W'(retire_next.count);
        end
    end

    ////////////////////////////////////////////////////////////
    // In-use tracking
    // ALU group finishes in one cycle and is left out
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_toggle <= '0;
            wb_toggle <= '0;
        end else begin
            if (iss.issue_mul) begin
                issue_toggle[iss.id] <= ~issue_toggle[iss.id];
            end
            if (wb.pkt[1].valid) begin
                wb_toggle[wb.pkt[1].id] <= ~wb_toggle[wb.pkt[1].id];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            retire_id_uses_rd[i] = uses_rd_table[retire_ids_next[i]];
            retire_id_inuse[i] = issue_toggle[retire_ids_next[i]]
                ^ wb_toggle[retire_ids_next[i]];
        end
    end

    ////////////////////////////////////////////////////////////
    // Retirer
    // Block starts at port 0, stops at the first gap or second rd writer
    always_comb begin
        contiguous = 1'b1;
        retire_next = '0;
        retire_next.rd_id = retire_ids_next[0];
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            retire_port_valid_next[i] = contiguous
                & (post_issue_count > COUNT_W'(i))
                & ~retire_id_inuse[i]
                & (~retire_id_uses_rd[i] | ~retire_next.valid);
            contiguous = retire_port_valid_next[i];
            if (retire_port_valid_next[i] & retire_id_uses_rd[i]) begin
                retire_next.valid = 1'b1;
                retire_next.rd_id = retire_ids_next[i];
            end
            retire_next.count = retire_next.count + 2'(retire_port_valid_next[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= '0;
            for (int i = 0; i < `RETIRE_PORTS; i++) begin
                retire_port_valid[i] <= 1'b0;
            end
        end else begin
            retire <= retire_next;
            retire_port_valid <= retire_port_valid_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    assign in_ready = ~inflight_count[COUNT_W-1];
    assign decode.valid = fetched_count_neg[COUNT_W-1];
    assign decode.id = decode_id;
    assign decode.instr = instr_table[decode_id];

    id_assigned_while_unavailable: assert property (
        @(posedge clk) disable iff (rst) !(in_accept & ~in_ready))
        else $error("ID assigned with all IDs in flight");

    decode_advanced_while_invalid: assert property (
        @(posedge clk) disable iff (rst) !(decode_advance & ~decode.valid))
        else $error("Decode advanced without a valid ID");

endmodule

`default_nettype wire

/* src/core_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Decode to execute groups, one strobe per group
interface issue_if;
    import core_pkg::*;

    logic issue_alu;
    logic issue_mul;
    id_t id;
    reg_addr_t rd;
    op_t op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;

    modport decode_side (
        output issue_alu, issue_mul, id, rd, op, operand_a, operand_b
    );
    modport exec_side (
        input issue_alu, issue_mul, id, rd, op, operand_a, operand_b
    );
    // ID tracking only needs which ID left decode and where
    modport monitor (
        input issue_alu, issue_mul, id
    );
endinterface

// Writeback, group 0 is the ALU and group 1 the multiplier
interface wb_if;
    import core_pkg::*;

    wb_packet_t pkt [2];

    modport source (output pkt);
    modport sink (input pkt);
endinterface

`default_nettype wire

/* src/core_pkg.sv */
`include "core_settings.svh"
`default_nettype none

package core_pkg;

    typedef logic [`LOG2_MAX_IDS-1:0] id_t;

    // x0 to x7, x0 hardwired to zero
    typedef logic [2:0] reg_addr_t;

    // Opcode sits in the top nibble of every word
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        XOR  = 4'h2,
        AND  = 4'h3,
        ADDI = 4'h4,
        MUL  = 4'h5,
        NOP  = 4'h6
    } op_t;

    // Register-register format
    typedef struct packed {
        op_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [18:0] unused;
    } r_fmt_t;

    // Register-immediate format, signed immediate in the low half
    typedef struct packed {
        op_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic [5:0] unused;
        logic signed [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef struct packed {
        logic valid;
        id_t id;
        instr_t instr;
    } decode_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        reg_addr_t rd;
        logic [31:0] data;
    } wb_packet_t;

    // valid marks that one of the retired instructions writes a register
    typedef struct packed {
        logic valid;
        logic [1:0] count;
        id_t rd_id;
    } retire_packet_t;

    // True for a known op with a nonzero destination
    function automatic logic writes_rd(instr_t instr);
        case (instr.r_fmt.op)
            ADD, SUB, XOR, AND, ADDI, MUL: return |instr.r_fmt.rd;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`default_nettype none

// Depth of the ID space and of every ID-indexed table
`define MAX_IDS 8
`define LOG2_MAX_IDS 3

// Instructions retired per cycle, at most one with a register write
`define RETIRE_PORTS 2

// Issue to writeback for the multiplier group
`define MUL_LATENCY 4

`default_nettype wire

`endif
